// ==== logic/raster_pkg.sv ====
package raster_pkg;

  // visible screen size in pixels
  localparam int H_RES = 640;
  localparam int V_RES = 480;

  // pixel coordinate, wide enough for either axis
  typedef logic [9:0] coord_t;

  // palette index
  typedef logic [7:0] color_t;

  // bresenham error term
  // holds +/- twice the longest span
  typedef logic signed [11:0] err_t;

  // normalization record carried down the pipe
  // bit 1 set when x and y were exchanged
  // bit 0 set when the minor axis runs downward
  typedef logic [1:0] octant_t;

  localparam int OCT_STEEP_BIT = 1;
  localparam int OCT_YNEG_BIT  = 0;

  // stepper FSM
  typedef enum logic {
    STEP_IDLE,
    STEP_RUN
  } step_state_t;

endpackage

// ==== logic/bus_pkg.sv ====
package bus_pkg;

  // framebuffer word address, y * H_RES + x
  localparam int WB_ADDR_W = 19;

  typedef logic [WB_ADDR_W-1:0] wb_addr_t;
  typedef logic [7:0]           wb_data_t;
  typedef logic [0:0]           wb_sel_t;

  // pixel bus master FSM
  typedef enum logic {
    WR_IDLE,
    WR_BUS
  } wr_state_t;

endpackage

// ==== logic/slope_classifier.sv ====
`timescale 1ns/1ps

module slope_classifier (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               cmd_valid,
  output logic               cmd_ready,
  input  raster_pkg::coord_t cmd_x_0,
  input  raster_pkg::coord_t cmd_y_0,
  input  raster_pkg::coord_t cmd_x_1,
  input  raster_pkg::coord_t cmd_y_1,
  input  raster_pkg::color_t cmd_color,
  output logic               s1_valid,
  input  logic               s1_ready,
  output raster_pkg::coord_t s1_x_0,
  output raster_pkg::coord_t s1_y_0,
  output raster_pkg::coord_t s1_x_1,
  output raster_pkg::coord_t s1_y_1,
  output raster_pkg::color_t s1_color,
  output logic               slope_steep
);
  import raster_pkg::*;

  // absolute spans of the command
  coord_t span_x;
  coord_t span_y;

  assign span_x = (cmd_x_1 >= cmd_x_0) ? (cmd_x_1 - cmd_x_0) : (cmd_x_0 - cmd_x_1);
  assign span_y = (cmd_y_1 >= cmd_y_0) ? (cmd_y_1 - cmd_y_0) : (cmd_y_0 - cmd_y_1);

  // free when empty or when the held command leaves this cycle
  assign cmd_ready = !s1_valid || s1_ready;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      s1_valid <= 1'b0;
    end else if (cmd_ready) begin
      s1_valid <= cmd_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (cmd_valid && cmd_ready) begin
      s1_x_0      <= cmd_x_0;
      s1_y_0      <= cmd_y_0;
      s1_x_1      <= cmd_x_1;
      s1_y_1      <= cmd_y_1;
      s1_color    <= cmd_color;
      // equal spans stay shallow
      slope_steep <= (span_y > span_x);
    end
  end

endmodule

// ==== logic/point_swapper.sv ====
`timescale 1ns/1ps

module point_swapper (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                s1_valid,
  output logic                s1_ready,
  input  raster_pkg::coord_t  s1_x_0,
  input  raster_pkg::coord_t  s1_y_0,
  input  raster_pkg::coord_t  s1_x_1,
  input  raster_pkg::coord_t  s1_y_1,
  input  raster_pkg::color_t  s1_color,
  input  logic                slope_steep,
  output logic                s2_valid,
  input  logic                s2_ready,
  output raster_pkg::coord_t  sx_0,
  output raster_pkg::coord_t  sy_0,
  output raster_pkg::coord_t  sx_1,
  output raster_pkg::coord_t  sy_1,
  output raster_pkg::color_t  s2_color,
  output raster_pkg::octant_t line_octant
);
  import raster_pkg::*;

  // endpoints after the axis exchange
  coord_t ax_0, ay_0, ax_1, ay_1;
  // endpoints after the order exchange
  coord_t nx_0, ny_0, nx_1, ny_1;
  logic   flip;

  // steep lines walk along y, so trade axes
  assign ax_0 = slope_steep ? s1_y_0 : s1_x_0;
  assign ay_0 = slope_steep ? s1_x_0 : s1_y_0;
  assign ax_1 = slope_steep ? s1_y_1 : s1_x_1;
  assign ay_1 = slope_steep ? s1_x_1 : s1_y_1;

  // major axis must never fall from point 0 to point 1
  assign flip = (ax_1 < ax_0);
  assign nx_0 = flip ? ax_1 : ax_0;
  assign ny_0 = flip ? ay_1 : ay_0;
  assign nx_1 = flip ? ax_0 : ax_1;
  assign ny_1 = flip ? ay_0 : ay_1;

  assign s1_ready = !s2_valid || s2_ready;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      s2_valid <= 1'b0;
    end else if (s1_ready) begin
      s2_valid <= s1_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (s1_valid && s1_ready) begin
      sx_0     <= nx_0;
      sy_0     <= ny_0;
      sx_1     <= nx_1;
      sy_1     <= ny_1;
      s2_color <= s1_color;
      // writer needs steep to undo the axis trade
      line_octant[OCT_STEEP_BIT] <= slope_steep;
      line_octant[OCT_YNEG_BIT]  <= (ny_1 < ny_0);
    end
  end

endmodule

// ==== logic/bresenham_stepper.sv ====
`timescale 1ns/1ps

module bresenham_stepper (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                s2_valid,
  output logic                s2_ready,
  input  raster_pkg::coord_t  sx_0,
  input  raster_pkg::coord_t  sy_0,
  input  raster_pkg::coord_t  sx_1,
  input  raster_pkg::coord_t  sy_1,
  input  raster_pkg::color_t  s2_color,
  input  raster_pkg::octant_t line_octant,
  output logic                pt_valid,
  input  logic                pt_ready,
  output raster_pkg::coord_t  pt_x,
  output raster_pkg::coord_t  pt_y,
  output raster_pkg::color_t  pt_color,
  output raster_pkg::octant_t pt_octant,
  output logic                idle
);
  import raster_pkg::*;

  step_state_t state;

  // current point in normalized space
  coord_t cur_x;
  coord_t cur_y;
  coord_t end_x;
  err_t   err;
  // doubled spans, kept for the whole line
  err_t   dx2;
  err_t   dy2;

  // spans of the incoming line
  coord_t dx;
  coord_t dy;
  logic   load;
  logic   advance;
  logic   last_pt;

  assign dx = sx_1 - sx_0;
  assign dy = line_octant[OCT_YNEG_BIT] ? (sy_0 - sy_1) : (sy_1 - sy_0);

  // one line at a time
  assign s2_ready = (state == STEP_IDLE);
  assign load     = s2_valid && s2_ready;
  assign pt_valid = (state == STEP_RUN);
  assign advance  = pt_valid && pt_ready;
  assign last_pt  = (cur_x == end_x);

  assign pt_x = cur_x;
  assign pt_y = cur_y;
  assign idle = (state == STEP_IDLE);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= STEP_IDLE;
    end else if (load) begin
      state <= STEP_RUN;
    end else if (advance && last_pt) begin
      state <= STEP_IDLE;
    end
  end

  always_ff @(posedge clk) begin
    if (load) begin
      cur_x     <= sx_0;
      cur_y     <= sy_0;
      end_x     <= sx_1;
      dx2       <= {1'b0, dx, 1'b0};
      dy2       <= {1'b0, dy, 1'b0};
      // 2*dy - dx
      err       <= {1'b0, dy, 1'b0} - err_t'({2'b00, dx});
      pt_color  <= s2_color;
      pt_octant <= line_octant;
    end else if (advance && !last_pt) begin
      cur_x <= cur_x + 1'b1;
      // zero error holds the minor axis
      if (err > err_t'(0)) begin
        cur_y <= pt_octant[OCT_YNEG_BIT] ? (cur_y - 1'b1) : (cur_y + 1'b1);
        err   <= err - dx2 + dy2;
      end else begin
        err <= err + dy2;
      end
    end
  end

endmodule

// ==== logic/pixel_writer.sv ====
`timescale 1ns/1ps

module pixel_writer (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                pt_valid,
  output logic                pt_ready,
  input  raster_pkg::coord_t  pt_x,
  input  raster_pkg::coord_t  pt_y,
  input  raster_pkg::color_t  pt_color,
  input  raster_pkg::octant_t pt_octant,
  output logic                wb_cyc,
  output logic                wb_stb,
  output logic                wb_we,
  output bus_pkg::wb_addr_t   wb_adr,
  output bus_pkg::wb_data_t   wb_dat_w,
  output bus_pkg::wb_sel_t    wb_sel,
  input  logic                wb_ack,
  output logic                idle
);
  import raster_pkg::*;
  import bus_pkg::*;

  wr_state_t state;
  // screen coordinates after undoing the axis trade
  coord_t    fb_x;
  coord_t    fb_y;
  logic      take;
  logic      active;

  assign fb_x = pt_octant[OCT_STEEP_BIT] ? pt_y : pt_x;
  assign fb_y = pt_octant[OCT_STEEP_BIT] ? pt_x : pt_y;

  assign pt_ready = (state == WR_IDLE);
  assign take     = pt_valid && pt_ready;
  assign active   = (state == WR_BUS);
  assign idle     = (state == WR_IDLE);

  // classic single write, cyc and stb move together
  assign wb_cyc = active;
  assign wb_stb = active;
  assign wb_we  = active;
  assign wb_sel = {$bits(wb_sel_t){active}};

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= WR_IDLE;
    end else if (take) begin
      state <= WR_BUS;
    end else if (active && wb_ack) begin
      // one idle cycle follows every ack
      state <= WR_IDLE;
    end
  end

  // address and data held until the ack
  always_ff @(posedge clk) begin
    if (take) begin
      wb_adr   <= wb_addr_t'(fb_y) * wb_addr_t'(H_RES) + wb_addr_t'(fb_x);
      wb_dat_w <= wb_data_t'(pt_color);
    end
  end

endmodule

// ==== logic/line_engine.sv ====
`timescale 1ns/1ps

module line_engine (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               cmd_valid,
  output logic               cmd_ready,
  input  raster_pkg::coord_t cmd_x_0,
  input  raster_pkg::coord_t cmd_y_0,
  input  raster_pkg::coord_t cmd_x_1,
  input  raster_pkg::coord_t cmd_y_1,
  input  raster_pkg::color_t cmd_color,
  output logic               wb_cyc,
  output logic               wb_stb,
  output logic               wb_we,
  output bus_pkg::wb_addr_t  wb_adr,
  output bus_pkg::wb_data_t  wb_dat_w,
  output bus_pkg::wb_sel_t   wb_sel,
  input  logic               wb_ack,
  output logic               busy
);
  import raster_pkg::*;

  // classifier to swapper
  logic    s1_valid, s1_ready, slope_steep;
  coord_t  s1_x_0, s1_y_0, s1_x_1, s1_y_1;
  color_t  s1_color;

  // swapper to stepper
  logic    s2_valid, s2_ready;
  coord_t  sx_0, sy_0, sx_1, sy_1;
  color_t  s2_color;
  octant_t line_octant;

  // stepper to writer, one point at a time
  logic    pt_valid, pt_ready;
  coord_t  pt_x, pt_y;
  color_t  pt_color;
  octant_t pt_octant;

  logic    step_idle;
  logic    wr_idle;

  slope_classifier i_slope_classifier (
    .clk, .rst_n,
    .cmd_valid, .cmd_ready, .cmd_x_0, .cmd_y_0, .cmd_x_1, .cmd_y_1, .cmd_color,
    .s1_valid, .s1_ready, .s1_x_0, .s1_y_0, .s1_x_1, .s1_y_1, .s1_color,
    .slope_steep
  );

  point_swapper i_point_swapper (
    .clk, .rst_n,
    .s1_valid, .s1_ready, .s1_x_0, .s1_y_0, .s1_x_1, .s1_y_1, .s1_color,
    .slope_steep,
    .s2_valid, .s2_ready, .sx_0, .sy_0, .sx_1, .sy_1, .s2_color, .line_octant
  );

  bresenham_stepper i_bresenham_stepper (
    .clk, .rst_n,
    .s2_valid, .s2_ready, .sx_0, .sy_0, .sx_1, .sy_1, .s2_color, .line_octant,
    .pt_valid, .pt_ready, .pt_x, .pt_y, .pt_color, .pt_octant,
    .idle (step_idle)
  );

  pixel_writer i_pixel_writer (
    .clk, .rst_n,
    .pt_valid, .pt_ready, .pt_x, .pt_y, .pt_color, .pt_octant,
    .wb_cyc, .wb_stb, .wb_we, .wb_adr, .wb_dat_w, .wb_sel, .wb_ack,
    .idle (wr_idle)
  );

  // anything still held or drawing in any stage
  assign busy = s1_valid || s2_valid || pt_valid || !step_idle || !wr_idle;

endmodule

// ==== test/line_engine_properties.sv ====
`timescale 1ns/1ps

module line_engine_properties (
  input logic              clk,
  input logic              rst_n,
  input logic              cmd_valid,
  input logic              cmd_ready,
  input logic              wb_cyc,
  input logic              wb_stb,
  input logic              wb_we,
  input bus_pkg::wb_addr_t wb_adr,
  input bus_pkg::wb_data_t wb_dat_w,
  input bus_pkg::wb_sel_t  wb_sel,
  input logic              wb_ack,
  input logic              busy
);
  // failed properties so far, watched from the testbench
  int fail_count = 0;

  // state in the first cycle out of reset
  reset_state: assert property (@(posedge clk)
    $rose(rst_n) |-> !wb_cyc && !wb_stb && !busy && cmd_ready)
    else begin
      fail_count = fail_count + 1;
      $error("bus, busy or cmd_ready not at reset values when reset released");
    end

  // slave stalls, master holds address and data
  hold_while_waiting: assert property (@(posedge clk) disable iff (!rst_n)
    wb_stb && !wb_ack |=> $stable(wb_adr) && $stable(wb_dat_w))
    else begin
      fail_count = fail_count + 1;
      $error("wb_adr or wb_dat_w changed before the ack");
    end

  cyc_with_stb: assert property (@(posedge clk) disable iff (!rst_n) wb_cyc == wb_stb)
    else begin
      fail_count = fail_count + 1;
      $error("wb_cyc and wb_stb differ");
    end

  // writes only, full select
  write_strobe: assert property (@(posedge clk) disable iff (!rst_n)
    wb_stb |-> wb_we && (&wb_sel))
    else begin
      fail_count = fail_count + 1;
      $error("wb_we or wb_sel low during a strobe");
    end

  // one dead cycle after every ack
  drop_after_ack: assert property (@(posedge clk) disable iff (!rst_n)
    wb_stb && wb_ack |=> !wb_cyc && !wb_stb)
    else begin
      fail_count = fail_count + 1;
      $error("cycle not dropped after the ack");
    end

  // empty pipe, first strobe exactly 4 cycles after acceptance
  first_pixel_latency: assert property (@(posedge clk) disable iff (!rst_n)
    cmd_valid && cmd_ready && !busy |=> !wb_stb ##1 !wb_stb ##1 !wb_stb ##1 wb_stb)
    else begin
      fail_count = fail_count + 1;
      $error("first strobe not 4 cycles after the command");
    end

endmodule

bind line_engine line_engine_properties i_line_engine_properties (
  .clk, .rst_n, .cmd_valid, .cmd_ready,
  .wb_cyc, .wb_stb, .wb_we, .wb_adr, .wb_dat_w, .wb_sel, .wb_ack, .busy
);

// ==== test/line_engine_tb.sv ====
`timescale 1ns/1ps

module line_engine_tb;
  import raster_pkg::*;
  import bus_pkg::*;

  localparam int NUM_LINES = 24;
  localparam int NUM_FIXED = 15;
  localparam int CLK_HALF  = 10;
  // up to 641 pixels per line and 5 cycles per write
  localparam int LIMIT_CYCLES = NUM_LINES * 641 * 5;
  // color above address in each expected entry
  localparam int EXP_W = $bits(color_t) + WB_ADDR_W;

  logic     clk = 1'b0;
  logic     rst_n;
  logic     cmd_valid;
  logic     cmd_ready;
  coord_t   cmd_x_0;
  coord_t   cmd_y_0;
  coord_t   cmd_x_1;
  coord_t   cmd_y_1;
  color_t   cmd_color;
  logic     wb_cyc;
  logic     wb_stb;
  logic     wb_we;
  wb_addr_t wb_adr;
  wb_data_t wb_dat_w;
  wb_sel_t  wb_sel;
  logic     wb_ack = 1'b0;
  logic     busy;

  // expected writes in bus order, plus the line each belongs to
  logic [EXP_W-1:0] exp_q[$];
  int               exp_line_q[$];
  logic [31:0]      rng = 32'h6ce029f2;
  // ack delays draw from their own stream
  logic [31:0]      ack_rng = 32'h6ce029f2;
  int               ack_wait = -1;
  logic             saw_stall = 1'b0;

  // axis aligned, single point, 45 degree, then one per octant around the center
  int fixed_lines [NUM_FIXED][4] = '{
    '{10, 20, 100, 20},
    '{300, 5, 250, 5},
    '{7, 400, 7, 300},
    '{600, 0, 600, 63},
    '{320, 240, 320, 240},
    '{0, 0, 50, 50},
    '{100, 100, 60, 140},
    '{320, 240, 350, 251},
    '{320, 240, 331, 270},
    '{320, 240, 309, 270},
    '{320, 240, 290, 251},
    '{320, 240, 290, 229},
    '{320, 240, 309, 210},
    '{320, 240, 331, 210},
    '{320, 240, 350, 229}
  };

  line_engine i_line_engine (
    .clk, .rst_n,
    .cmd_valid, .cmd_ready, .cmd_x_0, .cmd_y_0, .cmd_x_1, .cmd_y_1, .cmd_color,
    .wb_cyc, .wb_stb, .wb_we, .wb_adr, .wb_dat_w, .wb_sel, .wb_ack,
    .busy
  );

  initial begin
    forever #CLK_HALF clk = ~clk;
  end

  function automatic logic [31:0] xorshift(logic [31:0] state);
    state = state ^ (state << 13);
    state = state ^ (state >> 17);
    state = state ^ (state << 5);
    return state;
  endfunction

  // stimulus stream
  function automatic logic [31:0] next_rand();
    rng = xorshift(rng);
    return rng;
  endfunction

  task automatic report_mismatch(string name, int expected, int actual);
    $display("mismatch %s: expected %0d, actual %0d", name, expected, actual);
    $display("Simulation FAILED");
    $fatal(1, "stopped at first error");
  endtask

  task automatic abort_run(string what);
    $display("%s", what);
    $display("Simulation FAILED");
    $fatal(1, "run aborted");
  endtask

  // reference bresenham model pushes one entry per pixel
  task automatic push_expected(int line, int x0, int y0, int x1, int y1, color_t color);
    int       ax0;
    int       ay0;
    int       ax1;
    int       ay1;
    int       t;
    int       dx;
    int       dy;
    int       dir;
    int       err;
    int       y;
    bit       steep;
    wb_addr_t addr;
    steep = (y1 > y0 ? y1 - y0 : y0 - y1) > (x1 > x0 ? x1 - x0 : x0 - x1);
    // steep lines walk along y
    ax0 = steep ? y0 : x0;
    ay0 = steep ? x0 : y0;
    ax1 = steep ? y1 : x1;
    ay1 = steep ? x1 : y1;
    // major axis rises from point 0
    if (ax1 < ax0) begin
      t   = ax0;
      ax0 = ax1;
      ax1 = t;
      t   = ay0;
      ay0 = ay1;
      ay1 = t;
    end
    dx  = ax1 - ax0;
    dir = (ay1 < ay0) ? -1 : 1;
    dy  = (ay1 - ay0) * dir;
    err = 2 * dy - dx;
    y   = ay0;
    for (int x = ax0; x <= ax1; x++) begin
      addr = wb_addr_t'(steep ? x * H_RES + y : y * H_RES + x);
      exp_q.push_back({color, addr});
      exp_line_q.push_back(line);
      // zero error keeps the minor axis
      if (err > 0) begin
        y   = y + dir;
        err = err - 2 * dx;
      end
      err = err + 2 * dy;
    end
  endtask

  // starts and ends on a falling edge
  task automatic send_line(int line, int x0, int y0, int x1, int y1, color_t color, int gap);
    push_expected(line, x0, y0, x1, y1, color);
    cmd_x_0   = coord_t'(x0);
    cmd_y_0   = coord_t'(y0);
    cmd_x_1   = coord_t'(x1);
    cmd_y_1   = coord_t'(y1);
    cmd_color = color;
    cmd_valid = 1'b1;
    while (!cmd_ready) begin
      saw_stall = 1'b1;
      @(negedge clk);
    end
    @(negedge clk);
    cmd_valid = 1'b0;
    repeat (gap) @(negedge clk);
  endtask

  // framebuffer slave acks after 0 to 3 wait cycles
  always @(negedge clk) begin
    if (!rst_n || wb_ack || !wb_stb) begin
      wb_ack   = 1'b0;
      ack_wait = -1;
    end else begin
      if (ack_wait < 0) begin
        ack_rng  = xorshift(ack_rng);
        ack_wait = int'(ack_rng % 4);
      end
      if (ack_wait == 0) begin
        wb_ack = 1'b1;
      end else begin
        ack_wait = ack_wait - 1;
      end
    end
  end

  // bound property failures show up here half a cycle later
  always @(negedge clk) begin
    if (i_line_engine.i_line_engine_properties.fail_count != 0) begin
      abort_run("a bus or reset property of line_engine failed");
    end
  end

  // every acked write against the head of the expected queue
  always @(posedge clk) begin : check_write
    logic [EXP_W-1:0] exp;
    string            name;
    if (rst_n && wb_stb && wb_ack) begin
      assert (exp_q.size() != 0) else abort_run("write acked with no pixel left to draw");
      exp  = exp_q.pop_front();
      name = $sformatf("line_%0d", exp_line_q.pop_front());
      assert (wb_cyc) else abort_run("write acked while wb_cyc was low");
      assert (wb_adr == exp[WB_ADDR_W-1:0])
        else report_mismatch({name, " address"}, int'(exp[WB_ADDR_W-1:0]), int'(wb_adr));
      assert (wb_dat_w == exp[EXP_W-1:WB_ADDR_W])
        else report_mismatch({name, " color"}, int'(exp[EXP_W-1:WB_ADDR_W]), int'(wb_dat_w));
    end
  end

  initial begin
    #(LIMIT_CYCLES * 2 * CLK_HALF);
    abort_run($sformatf("timeout, run not done after %0d clock periods", LIMIT_CYCLES));
  end

  initial begin
    int x0;
    int y0;
    int x1;
    int y1;
    rst_n     = 1'b0;
    cmd_valid = 1'b0;
    cmd_x_0   = '0;
    cmd_y_0   = '0;
    cmd_x_1   = '0;
    cmd_y_1   = '0;
    cmd_color = '0;
    repeat (4) @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);
    for (int i = 0; i < NUM_FIXED; i++) begin
      // some commands start from an empty pipe
      if (i % 5 == 4) begin
        while (busy) @(negedge clk);
      end
      send_line(i, fixed_lines[i][0], fixed_lines[i][1], fixed_lines[i][2],
                fixed_lines[i][3], color_t'(8'h40 + i), (i % 3 == 0) ? 3 : 0);
    end
    for (int i = NUM_FIXED; i < NUM_LINES; i++) begin
      x0 = int'(next_rand() % H_RES);
      y0 = int'(next_rand() % V_RES);
      x1 = int'(next_rand() % H_RES);
      y1 = int'(next_rand() % V_RES);
      send_line(i, x0, y0, x1, y1, color_t'(next_rand()), int'(next_rand() % 3));
    end
    while (busy) @(negedge clk);
    // the drop check of the last ack lands on the next rising edge
    @(negedge clk);
    if (i_line_engine.i_line_engine_properties.fail_count != 0) begin
      abort_run("a bus or reset property of line_engine failed");
    end else if (exp_q.size() != 0) begin
      abort_run($sformatf("%0d expected pixels never written", exp_q.size()));
    end else if (!saw_stall) begin
      abort_run("cmd_ready never fell, the pipeline never filled");
    end else begin
      $display("Simulation PASSED");
      $finish;
    end
  end

endmodule

// ==== sources.f ====
logic/raster_pkg.sv
logic/bus_pkg.sv
logic/slope_classifier.sv
logic/point_swapper.sv
logic/bresenham_stepper.sv
logic/pixel_writer.sv
logic/line_engine.sv
test/line_engine_properties.sv
test/line_engine_tb.sv

// ==== Makefile ====
.PHONY: all run lint clean

all: run

run:
	verilator --binary --assert -Wno-fatal --top-module line_engine_tb -f sources.f
	./obj_dir/Vline_engine_tb +verilator+error+limit+100 > sim.log 2>&1; cat sim.log
	grep -q '^Simulation PASSED$$' sim.log

lint:
	verilator --lint-only --timing -Wall --top-module line_engine_tb -f sources.f

clean:
	rm -rf obj_dir sim.log
